//--- ooo_pkg.sv
package ooo_pkg;

    // Machine sizes
    localparam int ARCH_REGS  = 32;
    localparam int PR_ENTRIES = 64;
    localparam int PR_W       = 6;
    localparam int ROB_DEPTH  = 8;
    localparam int ROB_W      = 3;
    localparam int RS_SIZE    = 4;
    localparam int RS_W       = 2;
    localparam int IQ_DEPTH   = 4;
    localparam int IQ_W       = 2;
    // Free list covers the registers left over after the reset identity map
    localparam int FL_DEPTH   = PR_ENTRIES - ARCH_REGS;
    localparam int FL_W       = 5;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SLT
    } alu_op_e;

    // Decoded op as it enters the core
    typedef struct packed {
        alu_op_e     op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        // Operand b comes from imm instead of rs2
        logic        use_imm;
    } uop_t;

    // Op after rename, sent to ROB and reservation table
    typedef struct packed {
        uop_t             uop;
        logic [PR_W-1:0]  prd;
        logic [PR_W-1:0]  prs1;
        logic [PR_W-1:0]  prs2;
        logic [PR_W-1:0]  old_prd;
        logic [ROB_W-1:0] rob_id;
    } dispatch_t;

    // Issued op with operand values resolved
    typedef struct packed {
        alu_op_e          op;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [PR_W-1:0]  prd;
        logic [ROB_W-1:0] rob_id;
    } fu_input_t;

    typedef struct packed {
        logic             valid;
        logic [PR_W-1:0]  prd;
        logic [ROB_W-1:0] rob_id;
        logic [31:0]      value;
    } cdb_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] value;
        // Program order count from 0
        logic [31:0] seq;
    } commit_t;

endpackage

//--- inst_queue.sv
`timescale 1ns/1ps

module inst_queue (
    input  logic          clk,
    input  logic          rst,
    input  logic          push,
    input  ooo_pkg::uop_t in_uop,
    output logic          full,
    input  logic          pop,
    output ooo_pkg::uop_t head,
    output logic          empty
);

    ooo_pkg::uop_t mem [ooo_pkg::IQ_DEPTH];
    logic [ooo_pkg::IQ_W-1:0] rd_ptr;
    logic [ooo_pkg::IQ_W-1:0] wr_ptr;
    logic [ooo_pkg::IQ_W:0]   count;

    assign full  = count == ooo_pkg::IQ_DEPTH;
    assign empty = count == '0;
    // Head is visible to rename without a read cycle
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_uop;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own, depth is a power of two
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (ooo_pkg::IQ_W+1)'(push) - (ooo_pkg::IQ_W+1)'(pop);
        end
    end

    // Core gates push with in_ready and rename gates pop with empty
    assert property (@(posedge clk) disable iff (rst) push |-> !full);
    assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

//--- rename_unit.sv
`timescale 1ns/1ps

module rename_unit (
    input  logic                            clk,
    input  logic                            rst,
    input  ooo_pkg::uop_t                   head,
    input  logic                            iq_empty,
    output logic                            pop,
    input  logic                            rob_full,
    input  logic [ooo_pkg::ROB_W-1:0]       rob_id_next,
    input  logic                            rs_full,
    input  logic                            free_valid,
    input  logic [ooo_pkg::PR_W-1:0]        free_prd,
    output logic                            rd_alloc_valid,
    output logic [ooo_pkg::PR_W-1:0]        rd_alloc,
    output logic [ooo_pkg::PR_W-1:0]        prs1,
    output logic [ooo_pkg::PR_W-1:0]        prs2,
    output logic                            dispatch_valid,
    output ooo_pkg::dispatch_t              dispatch
);

    logic [ooo_pkg::PR_W-1:0] rat [ooo_pkg::ARCH_REGS];
    logic [ooo_pkg::PR_W-1:0] fl [ooo_pkg::FL_DEPTH];
    logic [ooo_pkg::FL_W-1:0] fl_head;
    logic [ooo_pkg::FL_W-1:0] fl_tail;
    logic [ooo_pkg::FL_W:0]   fl_count;
    logic                     needs_reg;

    // x0 keeps physical 0 and takes nothing from the free list
    assign needs_reg = head.rd != 5'd0;

    // Single dispatch decision for the whole core
    assign dispatch_valid = !iq_empty && !rob_full && !rs_full
                            && (!needs_reg || fl_count != '0);
    assign pop = dispatch_valid;

    // Sources read the map before this op's own update
    assign prs1 = rat[head.rs1];
    assign prs2 = rat[head.rs2];

    assign rd_alloc_valid = dispatch_valid && needs_reg;
    assign rd_alloc       = needs_reg ? fl[fl_head] : '0;

    always_comb begin
        dispatch.uop     = head;
        dispatch.prd     = rd_alloc;
        dispatch.prs1    = prs1;
        dispatch.prs2    = prs2;
        // Freed when this op commits
        dispatch.old_prd = rat[head.rd];
        dispatch.rob_id  = rob_id_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity map, free list holds 32 to 63
            for (int i = 0; i < ooo_pkg::ARCH_REGS; i++) begin
                rat[i] <= (ooo_pkg::PR_W)'(i);
            end
            for (int i = 0; i < ooo_pkg::FL_DEPTH; i++) begin
                fl[i] <= (ooo_pkg::PR_W)'(ooo_pkg::ARCH_REGS + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= (ooo_pkg::FL_W+1)'(ooo_pkg::FL_DEPTH);
        end else begin
            if (rd_alloc_valid) begin
                rat[head.rd] <= rd_alloc;
                fl_head      <= fl_head + 1'b1;
            end
            // Register returned by the ROB on commit
            if (free_valid) begin
                fl[fl_tail] <= free_prd;
                fl_tail     <= fl_tail + 1'b1;
            end
            fl_count <= fl_count + (ooo_pkg::FL_W+1)'(free_valid)
                        - (ooo_pkg::FL_W+1)'(rd_alloc_valid);
        end
    end

    // Underflow would wrap the free count above the pool size
    assert property (@(posedge clk) disable iff (rst)
                     fl_count <= (ooo_pkg::FL_W+1)'(ooo_pkg::FL_DEPTH));
    // ROB never hands back the permanent x0 register
    assert property (@(posedge clk) disable iff (rst) free_valid |-> free_prd != '0);

endmodule

//--- phys_reg_file.sv
`timescale 1ns/1ps

module phys_reg_file (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [ooo_pkg::PR_W-1:0] prs1,
    input  logic [ooo_pkg::PR_W-1:0] prs2,
    output logic [31:0]              rs1_value,
    output logic                     rs1_ready,
    output logic [31:0]              rs2_value,
    output logic                     rs2_ready,
    input  logic                     alloc_valid,
    input  logic [ooo_pkg::PR_W-1:0] alloc_prd,
    input  ooo_pkg::cdb_t            cdb
);

    logic [31:0] values [ooo_pkg::PR_ENTRIES];
    logic        ready  [ooo_pkg::PR_ENTRIES];

    // Combinational read for the dispatch cycle
    assign rs1_value = values[prs1];
    assign rs1_ready = ready[prs1];
    assign rs2_value = values[prs2];
    assign rs2_ready = ready[prs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ooo_pkg::PR_ENTRIES; i++) begin
                values[i] <= '0;
                ready[i]  <= 1'b1;
            end
        end else begin
            // New destination waits for its producer
            if (alloc_valid) begin
                ready[alloc_prd] <= 1'b0;
            end
            // Physical 0 ignores x0 writes on the bus
            if (cdb.valid && cdb.prd != '0) begin
                values[cdb.prd] <= cdb.value;
                ready[cdb.prd]  <= 1'b1;
            end
        end
    end

endmodule

//--- reservation_table.sv
`timescale 1ns/1ps

module reservation_table (
    input  logic               clk,
    input  logic               rst,
    input  logic               dispatch_valid,
    input  ooo_pkg::dispatch_t dispatch,
    input  logic [31:0]        rs1_value,
    input  logic               rs1_ready,
    input  logic [31:0]        rs2_value,
    input  logic               rs2_ready,
    input  ooo_pkg::cdb_t      cdb,
    output logic               issue_valid,
    output ooo_pkg::fu_input_t issue,
    output logic               full
);

    typedef struct packed {
        ooo_pkg::alu_op_e          op;
        logic [ooo_pkg::PR_W-1:0]  tag1;
        logic [ooo_pkg::PR_W-1:0]  tag2;
        logic                      rdy1;
        logic                      rdy2;
        logic [31:0]               val1;
        logic [31:0]               val2;
        logic                      use_imm;
        logic [31:0]               imm;
        logic [ooo_pkg::PR_W-1:0]  prd;
        logic [ooo_pkg::ROB_W-1:0] rob_id;
    } rs_entry_t;

    // Kept compacted, index 0 is the oldest
    rs_entry_t                ent  [ooo_pkg::RS_SIZE];
    rs_entry_t                woke [ooo_pkg::RS_SIZE];
    rs_entry_t                new_ent;
    logic [ooo_pkg::RS_W:0]   count;
    logic [ooo_pkg::RS_W:0]   ins_idx;
    logic [ooo_pkg::RS_W-1:0] issue_idx;

    // Capture a matching bus broadcast into a waiting source
    function automatic rs_entry_t wake(rs_entry_t e, ooo_pkg::cdb_t b);
        rs_entry_t w;
        w = e;
        if (!w.rdy1 && b.valid && b.prd == w.tag1) begin
            w.rdy1 = 1'b1;
            w.val1 = b.value;
        end
        if (!w.rdy2 && b.valid && b.prd == w.tag2) begin
            w.rdy2 = 1'b1;
            w.val2 = b.value;
        end
        return w;
    endfunction

    always_comb begin
        new_ent.op      = dispatch.uop.op;
        new_ent.tag1    = dispatch.prs1;
        new_ent.tag2    = dispatch.prs2;
        new_ent.rdy1    = rs1_ready;
        new_ent.val1    = rs1_value;
        // Immediate form has no second source to wait on
        new_ent.rdy2    = rs2_ready || dispatch.uop.use_imm;
        new_ent.val2    = rs2_value;
        new_ent.use_imm = dispatch.uop.use_imm;
        new_ent.imm     = dispatch.uop.imm;
        new_ent.prd     = dispatch.prd;
        new_ent.rob_id  = dispatch.rob_id;
        // Same-cycle bus hit on the entry being written
        new_ent = wake(new_ent, cdb);
        for (int i = 0; i < ooo_pkg::RS_SIZE; i++) begin
            woke[i] = wake(ent[i], cdb);
        end
    end

    // Oldest valid entry with both operands ready
    always_comb begin
        issue_valid = 1'b0;
        issue_idx   = '0;
        for (int i = ooo_pkg::RS_SIZE - 1; i >= 0; i--) begin
            if (i < count && ent[i].rdy1 && ent[i].rdy2) begin
                issue_valid = 1'b1;
                issue_idx   = (ooo_pkg::RS_W)'(i);
            end
        end
    end

    always_comb begin
        issue.op     = ent[issue_idx].op;
        issue.a      = ent[issue_idx].val1;
        issue.b      = ent[issue_idx].use_imm ? ent[issue_idx].imm : ent[issue_idx].val2;
        issue.prd    = ent[issue_idx].prd;
        issue.rob_id = ent[issue_idx].rob_id;
    end

    // New op lands behind the survivors
    assign ins_idx = count - (ooo_pkg::RS_W+1)'(issue_valid);
    assign full    = count == ooo_pkg::RS_SIZE;

    always_ff @(posedge clk) begin
        for (int i = 0; i < ooo_pkg::RS_SIZE; i++) begin
            // Close the gap left by the issued entry
            if (issue_valid && i >= issue_idx) begin
                if (i < ooo_pkg::RS_SIZE - 1) begin
                    ent[i] <= woke[i+1];
                end
            end else begin
                ent[i] <= woke[i];
            end
        end
        if (dispatch_valid) begin
            ent[ins_idx[ooo_pkg::RS_W-1:0]] <= new_ent;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= ins_idx + (ooo_pkg::RS_W+1)'(dispatch_valid);
        end
    end

    // Rename holds dispatch while the table is full
    assert property (@(posedge clk) disable iff (rst) dispatch_valid |-> !full);

endmodule

//--- alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    input  ooo_pkg::fu_input_t issue,
    output ooo_pkg::cdb_t      cdb
);

    logic [31:0] result;

    always_comb begin
        unique case (issue.op)
            ooo_pkg::ADD: result = issue.a + issue.b;
            ooo_pkg::SUB: result = issue.a - issue.b;
            ooo_pkg::AND: result = issue.a & issue.b;
            ooo_pkg::OR:  result = issue.a | issue.b;
            ooo_pkg::XOR: result = issue.a ^ issue.b;
            // Shift amount is the low 5 bits only
            ooo_pkg::SLL: result = issue.a << issue.b[4:0];
            ooo_pkg::SRL: result = issue.a >> issue.b[4:0];
            ooo_pkg::SLT: result = {31'b0, $signed(issue.a) < $signed(issue.b)};
            default:      result = '0;
        endcase
    end

    // Result goes out on the bus one cycle after issue
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid  <= issue_valid;
            cdb.prd    <= issue.prd;
            cdb.rob_id <= issue.rob_id;
            cdb.value  <= result;
        end
    end

endmodule

//--- rob.sv
`timescale 1ns/1ps

module rob (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dispatch_valid,
    input  ooo_pkg::dispatch_t        dispatch,
    output logic [ooo_pkg::ROB_W-1:0] rob_id_next,
    output logic                      full,
    input  ooo_pkg::cdb_t             cdb,
    output logic                      commit_valid,
    output ooo_pkg::commit_t          commit,
    output logic                      free_valid,
    output logic [ooo_pkg::PR_W-1:0]  free_prd
);

    logic [4:0]               rd_q    [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::PR_W-1:0] old_q   [ooo_pkg::ROB_DEPTH];
    logic                     done_q  [ooo_pkg::ROB_DEPTH];
    logic [31:0]              value_q [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::ROB_W-1:0] head;
    logic [ooo_pkg::ROB_W-1:0] tail;
    logic [ooo_pkg::ROB_W:0]   count;
    logic [31:0]               seq;
    logic                      head_done;

    assign rob_id_next = tail;
    assign full        = count == ooo_pkg::ROB_DEPTH;
    // Stale done bits past the tail are masked by count
    assign head_done   = count != '0 && done_q[head];

    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            rd_q[tail]   <= dispatch.uop.rd;
            old_q[tail]  <= dispatch.old_prd;
            done_q[tail] <= 1'b0;
        end
        // Completion by rob_id, never the free tail slot
        if (cdb.valid) begin
            done_q[cdb.rob_id]  <= 1'b1;
            value_q[cdb.rob_id] <= cdb.value;
        end
        if (head_done) begin
            commit.rd    <= rd_q[head];
            commit.value <= (rd_q[head] == 5'd0) ? 32'd0 : value_q[head];
            commit.seq   <= seq;
            free_prd     <= old_q[head];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            seq          <= '0;
            commit_valid <= 1'b0;
            free_valid   <= 1'b0;
        end else begin
            if (dispatch_valid) begin
                tail <= tail + 1'b1;
            end
            if (head_done) begin
                head <= head + 1'b1;
                seq  <= seq + 32'd1;
            end
            count        <= count + (ooo_pkg::ROB_W+1)'(dispatch_valid)
                            - (ooo_pkg::ROB_W+1)'(head_done);
            commit_valid <= head_done;
            // Old mapping of x0 is physical 0, which stays reserved
            free_valid   <= head_done && rd_q[head] != 5'd0;
        end
    end

    // Rename holds dispatch while the ROB is full
    assert property (@(posedge clk) disable iff (rst) dispatch_valid |-> !full);

endmodule

//--- ooo_core.sv
`timescale 1ns/1ps

module ooo_core (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  ooo_pkg::uop_t    in_uop,
    output logic             in_ready,
    output logic             commit_valid,
    output ooo_pkg::commit_t commit
);

    logic                      iq_push;
    logic                      iq_full;
    logic                      iq_empty;
    logic                      iq_pop;
    ooo_pkg::uop_t             iq_head;
    logic                      rob_full;
    logic [ooo_pkg::ROB_W-1:0] rob_id_next;
    logic                      rs_full;
    logic                      free_valid;
    logic [ooo_pkg::PR_W-1:0]  free_prd;
    logic                      alloc_valid;
    logic [ooo_pkg::PR_W-1:0]  alloc_prd;
    logic [ooo_pkg::PR_W-1:0]  prs1;
    logic [ooo_pkg::PR_W-1:0]  prs2;
    logic [31:0]               rs1_value;
    logic                      rs1_ready;
    logic [31:0]               rs2_value;
    logic                      rs2_ready;
    logic                      dispatch_valid;
    ooo_pkg::dispatch_t        dispatch;
    logic                      issue_valid;
    ooo_pkg::fu_input_t        issue;
    ooo_pkg::cdb_t             cdb;

    // Input handshake is the queue's free space
    assign in_ready = !iq_full;
    assign iq_push  = in_valid && in_ready;

    inst_queue iq (
        .clk(clk), .rst(rst),
        .push(iq_push), .in_uop(in_uop), .full(iq_full),
        .pop(iq_pop), .head(iq_head), .empty(iq_empty)
    );

    rename_unit rename (
        .clk(clk), .rst(rst),
        .head(iq_head), .iq_empty(iq_empty), .pop(iq_pop),
        .rob_full(rob_full), .rob_id_next(rob_id_next), .rs_full(rs_full),
        .free_valid(free_valid), .free_prd(free_prd),
        .rd_alloc_valid(alloc_valid), .rd_alloc(alloc_prd),
        .prs1(prs1), .prs2(prs2),
        .dispatch_valid(dispatch_valid), .dispatch(dispatch)
    );

    phys_reg_file prf (
        .clk(clk), .rst(rst),
        .prs1(prs1), .prs2(prs2),
        .rs1_value(rs1_value), .rs1_ready(rs1_ready),
        .rs2_value(rs2_value), .rs2_ready(rs2_ready),
        .alloc_valid(alloc_valid), .alloc_prd(alloc_prd),
        .cdb(cdb)
    );

    reservation_table alu_table (
        .clk(clk), .rst(rst),
        .dispatch_valid(dispatch_valid), .dispatch(dispatch),
        .rs1_value(rs1_value), .rs1_ready(rs1_ready),
        .rs2_value(rs2_value), .rs2_ready(rs2_ready),
        .cdb(cdb),
        .issue_valid(issue_valid), .issue(issue), .full(rs_full)
    );

    // Only producer on the data bus
    alu_unit alu (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue(issue), .cdb(cdb)
    );

    rob rb (
        .clk(clk), .rst(rst),
        .dispatch_valid(dispatch_valid), .dispatch(dispatch),
        .rob_id_next(rob_id_next), .full(rob_full),
        .cdb(cdb),
        .commit_valid(commit_valid), .commit(commit),
        .free_valid(free_valid), .free_prd(free_prd)
    );

endmodule

//--- tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;

    localparam int N_ROWS      = 19;
    localparam int BURST_OPS   = 24;
    localparam int WAIT_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 600;

    logic             clk;
    logic             rst;
    logic             in_valid;
    ooo_pkg::uop_t    in_uop;
    logic             in_ready;
    logic             commit_valid;
    ooo_pkg::commit_t commit;

    // Stimulus table, expected values worked out by hand
    string         row_name  [N_ROWS];
    ooo_pkg::uop_t row_uop   [N_ROWS];
    logic [31:0]   row_value [N_ROWS];

    // Scoreboard of outstanding ops, oldest first
    ooo_pkg::commit_t exp_q [$];
    string            exp_name_q [$];
    int               next_seq;
    bit               saw_stall;

    ooo_core UUT (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_uop(in_uop),
        .in_ready(in_ready),
        .commit_valid(commit_valid),
        .commit(commit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic ooo_pkg::uop_t make_uop(ooo_pkg::alu_op_e op, logic [4:0] rd,
                                               logic [4:0] rs1, logic [4:0] rs2,
                                               logic [31:0] imm, logic use_imm);
        ooo_pkg::uop_t u;
        u.op      = op;
        u.rd      = rd;
        u.rs1     = rs1;
        u.rs2     = rs2;
        u.imm     = imm;
        u.use_imm = use_imm;
        return u;
    endfunction

    task automatic add_row(int idx, string name, ooo_pkg::uop_t u, logic [31:0] value);
        row_name[idx]  = name;
        row_uop[idx]   = u;
        row_value[idx] = value;
    endtask

    // x1 and x2 are never written, every other source is written earlier in the table
    task automatic build_table();
        add_row(0,  "reset_read",   make_uop(ooo_pkg::ADD, 3, 1, 2, 0, 0), 32'h0);
        add_row(1,  "add_imm",      make_uop(ooo_pkg::ADD, 3, 0, 0, 100, 1), 32'h64);
        add_row(2,  "sub_imm",      make_uop(ooo_pkg::SUB, 4, 0, 0, 7, 1), 32'hFFFF_FFF9);
        add_row(3,  "and_imm",      make_uop(ooo_pkg::AND, 5, 4, 0, 32'hF0, 1), 32'hF0);
        add_row(4,  "or_imm",       make_uop(ooo_pkg::OR, 6, 3, 0, 32'hF00, 1), 32'hF64);
        add_row(5,  "xor_imm",      make_uop(ooo_pkg::XOR, 7, 3, 0, 32'hFF, 1), 32'h9B);
        add_row(6,  "sll_imm",      make_uop(ooo_pkg::SLL, 8, 3, 0, 4, 1), 32'h640);
        add_row(7,  "srl_imm",      make_uop(ooo_pkg::SRL, 9, 4, 0, 28, 1), 32'hF);
        // -7 < 5 signed
        add_row(8,  "slt_true",     make_uop(ooo_pkg::SLT, 10, 4, 0, 5, 1), 32'h1);
        add_row(9,  "slt_false",    make_uop(ooo_pkg::SLT, 11, 3, 0, 32'hFFFF_FFFF, 1), 32'h0);
        // Shift of 33 keeps only 1
        add_row(10, "sll_low5",     make_uop(ooo_pkg::SLL, 12, 3, 0, 33, 1), 32'hC8);
        // Back to back chain through x13
        add_row(11, "chain_add",    make_uop(ooo_pkg::ADD, 13, 3, 0, 1, 1), 32'h65);
        add_row(12, "chain_double", make_uop(ooo_pkg::ADD, 13, 13, 13, 0, 0), 32'hCA);
        add_row(13, "chain_sub",    make_uop(ooo_pkg::SUB, 14, 13, 3, 0, 0), 32'h66);
        add_row(14, "chain_xor",    make_uop(ooo_pkg::XOR, 13, 14, 13, 0, 0), 32'hAC);
        add_row(15, "chain_srl",    make_uop(ooo_pkg::SRL, 15, 13, 10, 0, 0), 32'h56);
        add_row(16, "chain_slt",    make_uop(ooo_pkg::SLT, 16, 4, 15, 0, 0), 32'h1);
        // x0 target commits zero, x0 source still reads zero
        add_row(17, "x0_write",     make_uop(ooo_pkg::ADD, 0, 3, 0, 5, 1), 32'h0);
        add_row(18, "x0_read",      make_uop(ooo_pkg::ADD, 17, 0, 3, 0, 0), 32'h64);
    endtask

    task automatic fail_now(string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    // Called just after a falling edge, returns one falling edge after acceptance
    task automatic send_uop(string name, ooo_pkg::uop_t u, logic [31:0] value);
        int               waited;
        ooo_pkg::commit_t c;
        waited   = 0;
        in_valid = 1'b1;
        in_uop   = u;
        // in_ready only moves on the rising edge
        while (!in_ready) begin
            saw_stall = 1'b1;
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_now($sformatf("Timed out waiting for in_ready to accept %s", name));
            end
        end
        c.rd    = u.rd;
        c.value = value;
        c.seq   = next_seq;
        next_seq++;
        exp_q.push_back(c);
        exp_name_q.push_back(name);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain(string phase);
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                fail_now($sformatf("Timed out waiting for the %s ops to commit", phase));
            end
        end
    endtask

    // Commit outputs are registered, stable on the falling edge
    always @(negedge clk) begin : commit_monitor
        ooo_pkg::commit_t e;
        string            n;
        if (!rst && commit_valid) begin
            if (exp_q.size() == 0) begin
                fail_now("A commit appeared with no op outstanding");
            end else begin
                e = exp_q.pop_front();
                n = exp_name_q.pop_front();
                check_value({n, " rd"}, 32'(e.rd), 32'(commit.rd));
                check_value({n, " value"}, e.value, commit.value);
                check_value({n, " seq"}, e.seq, commit.seq);
            end
        end
    end

    initial begin
        int gap;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_uop    = '0;
        next_seq  = 0;
        saw_stall = 1'b0;
        void'($urandom(35));
        build_table();

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Idle core after reset
        repeat (4) begin
            @(negedge clk);
            check_value("reset commit_valid", 32'd0, 32'(commit_valid));
            check_value("reset in_ready", 32'd1, 32'(in_ready));
        end

        // Table back to back
        for (int i = 0; i < N_ROWS; i++) begin
            send_uop(row_name[i], row_uop[i], row_value[i]);
        end
        wait_drain("table");

        // 48 writes over x20..x22, more than the free list holds
        for (int r = 0; r < 16; r++) begin
            send_uop($sformatf("recycle_x20_%0d", r),
                     make_uop(ooo_pkg::ADD, 20, 20, 0, 1, 1), 32'(r + 1));
            send_uop($sformatf("recycle_x21_%0d", r),
                     make_uop(ooo_pkg::ADD, 21, 21, 0, 2, 1), 32'(2 * (r + 1)));
            send_uop($sformatf("recycle_x22_%0d", r),
                     make_uop(ooo_pkg::ADD, 22, 22, 0, 3, 1), 32'(3 * (r + 1)));
        end
        send_uop("recycle_sum", make_uop(ooo_pkg::SUB, 23, 22, 20, 0, 0), 32'd32);
        wait_drain("recycle");

        // Long dependent burst, issue rate falls behind the input
        saw_stall = 1'b0;
        for (int k = 0; k < BURST_OPS; k++) begin
            send_uop($sformatf("burst_%0d", k),
                     make_uop(ooo_pkg::ADD, 24, 24, 0, 3, 1), 32'(3 * (k + 1)));
        end
        wait_drain("burst");
        check_value("burst in_ready dropped", 32'd1, 32'(saw_stall));
        check_value("burst in_ready recovered", 32'd1, 32'(in_ready));

        // Table again with random idle gaps
        for (int i = 0; i < N_ROWS; i++) begin
            gap = int'($urandom % 4);
            repeat (gap) @(negedge clk);
            send_uop({"stall_", row_name[i]}, row_uop[i], row_value[i]);
        end
        wait_drain("random stall");

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- filelist.f
ooo_pkg.sv
inst_queue.sv
rename_unit.sv
phys_reg_file.sv
reservation_table.sv
alu_unit.sv
rob.sv
ooo_core.sv
tb_ooo_core.sv
